// File: src/fft_cfg.svh
`ifndef FFT_CFG_SVH
`define FFT_CFG_SVH

// width of one real or imaginary sample
`define SAMPLE_W 9

// fraction bits carried by each twiddle
`define TWID_FRAC 7

// transform length and how it is spread over the units
`define NUM_POINTS 32
`define NUM_LANES 4
`define NUM_UNITS 8

`endif

// File: src/fftCtrlPkg.sv
package fftCtrlPkg;

  // pass sequence of one transform
  typedef enum logic [1:0] {idle, passA, passB, passC} fftStateT;

  // butterfly opcode, radix-2 skips the twiddle multiply
  typedef enum logic {modeRadix4, modeRadix2} bflyModeT;

  // what the router does on a load strobe
  typedef enum logic [1:0] {loadInput, loadPassB, loadPassC, storeOutput} routeSelT;

endpackage

// File: src/fftDataPkg.sv
`include "fft_cfg.svh"

package fftDataPkg;

  typedef logic signed [`SAMPLE_W-1:0] sampleT;

  // same width as a sample, TWID_FRAC bits below the point
  typedef logic signed [`SAMPLE_W-1:0] twiddleT;

  // lane 0 in the low bits
  typedef sampleT [`NUM_LANES-1:0] laneVecT;

  // slot n at bits n*SAMPLE_W
  typedef sampleT [`NUM_POINTS-1:0] pointVecT;

endpackage

// File: src/twiddleMul.sv
`timescale 1ns/1ns
`include "fft_cfg.svh"

module twiddleMul import fftDataPkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  sampleT  xRe,
  input  sampleT  xIm,
  input  twiddleT wRe,
  input  twiddleT wIm,
  input  logic    bypass,
  output sampleT  pRe,
  output sampleT  pIm
);

  localparam int ProdW = 2 * `SAMPLE_W;

  logic signed [ProdW-1:0] prodRe;
  logic signed [ProdW-1:0] prodIm;

  // full-width complex product
  assign prodRe = xRe * wRe - xIm * wIm;
  assign prodIm = xRe * wIm + xIm * wRe;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pRe <= '0;
      pIm <= '0;
    end else if (bypass) begin
      pRe <= xRe;
      pIm <= xIm;
    end else begin
      // drop the fraction bits (floor), upper bits wrap away
      pRe <= prodRe[`TWID_FRAC +: `SAMPLE_W];
      pIm <= prodIm[`TWID_FRAC +: `SAMPLE_W];
    end
  end

endmodule

// File: src/butterflyUnit.sv
`timescale 1ns/1ns
`include "fft_cfg.svh"

module butterflyUnit import fftDataPkg::*, fftCtrlPkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     start,
  input  bflyModeT mode,
  input  laneVecT  inRe,
  input  laneVecT  inIm,
  input  laneVecT  twRe,
  input  laneVecT  twIm,
  output laneVecT  outRe,
  output laneVecT  outIm,
  output logic     done
);

  // room for four summed terms
  localparam int SumW = `SAMPLE_W + 2;

  sampleT                aRe  [`NUM_LANES];
  sampleT                aIm  [`NUM_LANES];
  logic                  startQ;
  bflyModeT              modeQ;
  logic signed [SumW-1:0] r4Re [`NUM_LANES];
  logic signed [SumW-1:0] r4Im [`NUM_LANES];
  logic signed [SumW-1:0] r2Re [`NUM_LANES];
  logic signed [SumW-1:0] r2Im [`NUM_LANES];

  // stage 1, one multiplier per lane
  for (genvar k = 0; k < `NUM_LANES; k++) begin : gLane
    twiddleMul uMul (
      .clk(clk),
      .rst(rst),
      .xRe(inRe[k]),
      .xIm(inIm[k]),
      .wRe(twRe[k]),
      .wIm(twIm[k]),
      .bypass(mode == modeRadix2),
      .pRe(aRe[k]),
      .pIm(aIm[k])
    );
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      startQ <= 1'b0;
      modeQ  <= modeRadix4;
      done   <= 1'b0;
    end else begin
      startQ <= start;
      modeQ  <= mode;
      done   <= startQ;
    end
  end

  // radix-4 kernel, multiplying by j swaps re and im with a sign flip
  always_comb begin
    r4Re[0] = aRe[0] + aRe[1] + aRe[2] + aRe[3];
    r4Im[0] = aIm[0] + aIm[1] + aIm[2] + aIm[3];
    r4Re[1] = aRe[0] + aIm[1] - aRe[2] - aIm[3];
    r4Im[1] = aIm[0] - aRe[1] - aIm[2] + aRe[3];
    r4Re[2] = aRe[0] - aRe[1] + aRe[2] - aRe[3];
    r4Im[2] = aIm[0] - aIm[1] + aIm[2] - aIm[3];
    r4Re[3] = aRe[0] - aIm[1] - aRe[2] + aIm[3];
    r4Im[3] = aIm[0] + aRe[1] - aIm[2] - aRe[3];
  end

  // two independent radix-2 pairs
  always_comb begin
    r2Re[0] = aRe[0] + aRe[1];
    r2Im[0] = aIm[0] + aIm[1];
    r2Re[1] = aRe[0] - aRe[1];
    r2Im[1] = aIm[0] - aIm[1];
    r2Re[2] = aRe[2] + aRe[3];
    r2Im[2] = aIm[2] + aIm[3];
    r2Re[3] = aRe[2] - aRe[3];
    r2Im[3] = aIm[2] - aIm[3];
  end

  // stage 2, results scaled down and held until the next start
  always_ff @(posedge clk) begin
    if (startQ) begin
      for (int k = 0; k < `NUM_LANES; k++) begin
        if (modeQ == modeRadix2) begin
          outRe[k] <= r2Re[k][`SAMPLE_W:1];
          outIm[k] <= r2Im[k][`SAMPLE_W:1];
        end else begin
          outRe[k] <= r4Re[k][SumW-1:2];
          outIm[k] <= r4Im[k][SumW-1:2];
        end
      end
    end
  end

endmodule

// File: src/fftController.sv
`timescale 1ns/1ns
`include "fft_cfg.svh"

module fftController import fftCtrlPkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     fftStart,
  input  logic     unitDone,
  output logic     unitStart,
  output logic     routeLoad,
  output routeSelT routeSel,
  output bflyModeT unitMode,
  output logic     fftDone
);

  fftStateT state;

  // a start while busy never reaches the router
  assign routeLoad = (state == idle) ? fftStart : unitDone;

  always_comb begin
    case (state)
      idle:    routeSel = loadInput;
      passA:   routeSel = loadPassB;
      passB:   routeSel = loadPassC;
      default: routeSel = storeOutput;
    endcase
  end

  // last pass runs without twiddles
  assign unitMode = (state == passC) ? modeRadix2 : modeRadix4;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state     <= idle;
      unitStart <= 1'b0;
      fftDone   <= 1'b0;
    end else begin
      unitStart <= routeLoad && (state != passC);
      fftDone   <= unitDone && (state == passC);
      if (routeLoad) begin
        case (state)
          idle:    state <= passA;
          passA:   state <= passB;
          passB:   state <= passC;
          default: state <= idle;
        endcase
      end
    end
  end

endmodule

// File: src/stageRouter.sv
`timescale 1ns/1ns
`include "fft_cfg.svh"

module stageRouter import fftDataPkg::*, fftCtrlPkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     routeLoad,
  input  routeSelT routeSel,
  input  pointVecT inReal,
  input  pointVecT inImag,
  input  pointVecT twReal,
  input  pointVecT twImag,
  input  laneVecT  resRe [`NUM_UNITS],
  input  laneVecT  resIm [`NUM_UNITS],
  output laneVecT  opRe [`NUM_UNITS],
  output laneVecT  opIm [`NUM_UNITS],
  output laneVecT  opTwRe [`NUM_UNITS],
  output laneVecT  opTwIm [`NUM_UNITS],
  output pointVecT outReal,
  output pointVecT outImag
);

  // operands and twiddle bank for the next pass
  always_ff @(posedge clk) begin
    if (routeLoad) begin
      case (routeSel)
        loadInput: begin
          for (int u = 0; u < `NUM_UNITS; u++) begin
            // unit u takes every eighth sample starting at u
            for (int k = 0; k < `NUM_LANES; k++) begin
              opRe[u][k] <= inReal[u + `NUM_UNITS * k];
              opIm[u][k] <= inImag[u + `NUM_UNITS * k];
            end
            opTwRe[u] <= twReal[`NUM_LANES * u +: `NUM_LANES];
            opTwIm[u] <= twImag[`NUM_LANES * u +: `NUM_LANES];
          end
        end
        loadPassB: begin
          for (int u = 0; u < `NUM_UNITS; u++) begin
            // unit 2m+p gathers lane m of units p, p+2, p+4, p+6
            for (int k = 0; k < `NUM_LANES; k++) begin
              opRe[u][k] <= resRe[u % 2 + 2 * k][u / 2];
              opIm[u][k] <= resIm[u % 2 + 2 * k][u / 2];
            end
            // pass B reuses the twiddles that units 0 and 4 had in pass A
            opTwRe[u] <= opTwRe[4 * (u % 2)];
            opTwIm[u] <= opTwIm[4 * (u % 2)];
          end
        end
        loadPassC: begin
          for (int u = 0; u < `NUM_UNITS; u++) begin
            // interleave one lane pair of units 2m and 2m+1
            for (int k = 0; k < `NUM_LANES; k++) begin
              opRe[u][k] <= resRe[2 * (u / 2) + k % 2][2 * (u % 2) + k / 2];
              opIm[u][k] <= resIm[2 * (u / 2) + k % 2][2 * (u % 2) + k / 2];
            end
          end
        end
        default: begin
        end
      endcase
    end
  end

  // final reorder into natural output slots, held between transforms
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      outReal <= '0;
      outImag <= '0;
    end else if (routeLoad && (routeSel == storeOutput)) begin
      for (int s = 0; s < `NUM_POINTS; s++) begin
        // c = s/4: bit 1 picks the odd unit, bits 0 and 2 pick the lane
        outReal[s] <= resRe[2 * (s % 4) + (s / 8) % 2][2 * ((s / 4) % 2) + s / 16];
        outImag[s] <= resIm[2 * (s % 4) + (s / 8) % 2][2 * ((s / 4) % 2) + s / 16];
      end
    end
  end

endmodule

// File: src/fftTop.sv
`timescale 1ns/1ns
`include "fft_cfg.svh"

module fftTop import fftDataPkg::*, fftCtrlPkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     fftStart,
  input  pointVecT inReal,
  input  pointVecT inImag,
  input  pointVecT twReal,
  input  pointVecT twImag,
  output pointVecT outReal,
  output pointVecT outImag,
  output logic     fftDone
);

  logic                  unitStart;
  logic                  unitDone;
  logic                  routeLoad;
  routeSelT              routeSel;
  bflyModeT              unitMode;
  logic [`NUM_UNITS-1:0] doneVec;
  laneVecT               opRe   [`NUM_UNITS];
  laneVecT               opIm   [`NUM_UNITS];
  laneVecT               opTwRe [`NUM_UNITS];
  laneVecT               opTwIm [`NUM_UNITS];
  laneVecT               resRe  [`NUM_UNITS];
  laneVecT               resIm  [`NUM_UNITS];

  // all units run in lockstep, unit 0 alone paces the sequence
  assign unitDone = doneVec[0];

  fftController uCtrl (
    .clk(clk),
    .rst(rst),
    .fftStart(fftStart),
    .unitDone(unitDone),
    .unitStart(unitStart),
    .routeLoad(routeLoad),
    .routeSel(routeSel),
    .unitMode(unitMode),
    .fftDone(fftDone)
  );

  stageRouter uRouter (
    .clk(clk),
    .rst(rst),
    .routeLoad(routeLoad),
    .routeSel(routeSel),
    .inReal(inReal),
    .inImag(inImag),
    .twReal(twReal),
    .twImag(twImag),
    .resRe(resRe),
    .resIm(resIm),
    .opRe(opRe),
    .opIm(opIm),
    .opTwRe(opTwRe),
    .opTwIm(opTwIm),
    .outReal(outReal),
    .outImag(outImag)
  );

  for (genvar u = 0; u < `NUM_UNITS; u++) begin : gUnit
    butterflyUnit uBfly (
      .clk(clk),
      .rst(rst),
      .start(unitStart),
      .mode(unitMode),
      .inRe(opRe[u]),
      .inIm(opIm[u]),
      .twRe(opTwRe[u]),
      .twIm(opTwIm[u]),
      .outRe(resRe[u]),
      .outIm(resIm[u]),
      .done(doneVec[u])
    );
  end

endmodule

// File: tb/tbClock.sv
`timescale 1ns/1ns

module tbClock (
  output logic clk
);

  // 8 ns period
  initial clk = 1'b0;
  always #4 clk = ~clk;

endmodule

// File: tb/fft_asserts.sv
`timescale 1ns/1ns

module fft_asserts (
  input logic clk,
  input logic rst,
  input logic fftDone,
  input logic unitStart,
  input logic unitDone,
  input logic routeLoad
);

  // done is a single-cycle pulse
  doneOneCycle: assert property (@(posedge clk) disable iff (!rst)
    !(fftDone && $past(fftDone)))
    else $error("fftDone high for two consecutive cycles");

  // units answer two cycles after their start
  unitLatency: assert property (@(posedge clk) disable iff (!rst)
    unitDone == $past(unitStart, 2))
    else $error("unitDone does not follow unitStart by two cycles");

  quietInReset: assert property (@(posedge clk) !rst |-> (!fftDone && !routeLoad))
    else $error("fftDone or routeLoad active during reset");

endmodule

bind fftTop fft_asserts uAsserts (
  .clk(clk),
  .rst(rst),
  .fftDone(fftDone),
  .unitStart(unitStart),
  .unitDone(unitDone),
  .routeLoad(routeLoad)
);

// File: tb/fftTb.sv
`timescale 1ns/1ns
`include "fft_cfg.svh"

module fftTb import fftDataPkg::*; ();

  // fftDone is set by the 9th edge after acceptance, so it is seen at the 10th
  localparam int DoneSeenEdge = 10;
  localparam int DoneTimeout  = 40;

  logic     clk;
  logic     rst;
  logic     fftStart;
  pointVecT inReal;
  pointVecT inImag;
  pointVecT twReal;
  pointVecT twImag;
  pointVecT outReal;
  pointVecT outImag;
  logic     fftDone;

  logic [31:0] lfsrState;
  int edgeCount  = 0;
  int acceptEdge;

  int xr   [`NUM_POINTS];
  int xi   [`NUM_POINTS];
  int wr   [`NUM_POINTS];
  int wi   [`NUM_POINTS];
  int expR [`NUM_POINTS];
  int expI [`NUM_POINTS];
  int opR  [`NUM_UNITS][`NUM_LANES];
  int opI  [`NUM_UNITS][`NUM_LANES];
  int twR  [`NUM_UNITS][`NUM_LANES];
  int twI  [`NUM_UNITS][`NUM_LANES];
  int resR [`NUM_UNITS][`NUM_LANES];
  int resI [`NUM_UNITS][`NUM_LANES];

  tbClock uClock (.clk(clk));

  fftTop i_dut (
    .clk(clk),
    .rst(rst),
    .fftStart(fftStart),
    .inReal(inReal),
    .inImag(inImag),
    .twReal(twReal),
    .twImag(twImag),
    .outReal(outReal),
    .outImag(outImag),
    .fftDone(fftDone)
  );

  always @(posedge clk) edgeCount <= edgeCount + 1;

  // galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsrBit();
    logic outBit;
    outBit = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (outBit) lfsrState = lfsrState ^ 32'h80200003;
    return outBit;
  endfunction

  function automatic int randomSample();
    logic [`SAMPLE_W-1:0] raw;
    for (int b = 0; b < `SAMPLE_W; b++) raw[b] = lfsrBit();
    return int'($signed(raw));
  endfunction

  function automatic int wrapSample(input int v);
    int low;
    low = v & ((1 << `SAMPLE_W) - 1);
    if (low >= (1 << (`SAMPLE_W - 1))) low = low - (1 << `SAMPLE_W);
    return low;
  endfunction

  function automatic void fillRandom(input bit zeroTwiddles);
    for (int n = 0; n < `NUM_POINTS; n++) begin
      xr[n] = randomSample();
      xi[n] = randomSample();
      wr[n] = zeroTwiddles ? 0 : randomSample();
      wi[n] = zeroTwiddles ? 0 : randomSample();
    end
  endfunction

  // one pass over all eight units with products a0..a3 then the kernel
  function automatic void runButterflies(input bit radix4);
    int aR [`NUM_LANES];
    int aI [`NUM_LANES];
    int sumR;
    int sumI;
    for (int u = 0; u < `NUM_UNITS; u++) begin
      for (int k = 0; k < `NUM_LANES; k++) begin
        aR[k] = opR[u][k];
        aI[k] = opI[u][k];
        if (radix4) begin
          aR[k] = wrapSample((opR[u][k] * twR[u][k] - opI[u][k] * twI[u][k]) >>> `TWID_FRAC);
          aI[k] = wrapSample((opR[u][k] * twI[u][k] + opI[u][k] * twR[u][k]) >>> `TWID_FRAC);
        end
      end
      if (radix4) begin
        // output y sums a[n] turned by (-j)^(n*y)
        for (int y = 0; y < `NUM_LANES; y++) begin
          sumR = 0;
          sumI = 0;
          for (int n = 0; n < `NUM_LANES; n++) begin
            case ((n * y) % 4)
              0: begin
                sumR += aR[n];
                sumI += aI[n];
              end
              1: begin
                // -j*(r + j*i) = i - j*r
                sumR += aI[n];
                sumI -= aR[n];
              end
              2: begin
                sumR -= aR[n];
                sumI -= aI[n];
              end
              default: begin
                sumR -= aI[n];
                sumI += aR[n];
              end
            endcase
          end
          resR[u][y] = wrapSample(sumR >>> 2);
          resI[u][y] = wrapSample(sumI >>> 2);
        end
      end else begin
        for (int q = 0; q < 2; q++) begin
          resR[u][2 * q] = wrapSample((aR[2 * q] + aR[2 * q + 1]) >>> 1);
          resI[u][2 * q] = wrapSample((aI[2 * q] + aI[2 * q + 1]) >>> 1);
          resR[u][2 * q + 1] = wrapSample((aR[2 * q] - aR[2 * q + 1]) >>> 1);
          resI[u][2 * q + 1] = wrapSample((aI[2 * q] - aI[2 * q + 1]) >>> 1);
        end
      end
    end
  endfunction

  // reference transform of xr/xi with wr/wi into expR/expI
  function automatic void fftModel();
    int u;
    int c;
    for (u = 0; u < `NUM_UNITS; u++) begin
      for (int k = 0; k < `NUM_LANES; k++) begin
        opR[u][k] = xr[u + 8 * k];
        opI[u][k] = xi[u + 8 * k];
        twR[u][k] = wr[4 * u + k];
        twI[u][k] = wi[4 * u + k];
      end
    end
    runButterflies(1'b1);
    for (int m = 0; m < 4; m++) begin
      for (int p = 0; p < 2; p++) begin
        u = 2 * m + p;
        for (int k = 0; k < `NUM_LANES; k++) begin
          opR[u][k] = resR[p + 2 * k][m];
          opI[u][k] = resI[p + 2 * k][m];
          // slots of pass-A unit 0 or unit 4
          twR[u][k] = wr[16 * p + k];
          twI[u][k] = wi[16 * p + k];
        end
      end
    end
    runButterflies(1'b1);
    for (int m = 0; m < 4; m++) begin
      for (int h = 0; h < 2; h++) begin
        for (int k = 0; k < `NUM_LANES; k++) begin
          opR[2 * m + h][k] = resR[2 * m + k % 2][2 * h + k / 2];
          opI[2 * m + h][k] = resI[2 * m + k % 2][2 * h + k / 2];
        end
      end
    end
    runButterflies(1'b0);
    for (int s = 0; s < `NUM_POINTS; s++) begin
      c = s / 4;
      expR[s] = resR[2 * (s % 4) + ((c >> 1) & 1)][2 * (c & 1) + ((c >> 2) & 1)];
      expI[s] = resI[2 * (s % 4) + ((c >> 1) & 1)][2 * (c & 1) + ((c >> 2) & 1)];
    end
  endfunction

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("sim failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic checkValue(input string testName, input int expected, input int actual);
    if (expected !== actual) begin
      abortRun($sformatf("CHECK FAILED %s expected %0d actual %0d",
                         testName, expected, actual));
    end
  endtask

  task automatic checkOutputs(input string name, input bit expectZero);
    for (int s = 0; s < `NUM_POINTS; s++) begin
      checkValue($sformatf("%s re[%0d]", name, s), expectZero ? 0 : expR[s],
                 int'($signed(outReal[s])));
      checkValue($sformatf("%s im[%0d]", name, s), expectZero ? 0 : expI[s],
                 int'($signed(outImag[s])));
    end
  endtask

  task automatic driveData();
    for (int n = 0; n < `NUM_POINTS; n++) begin
      inReal[n] <= sampleT'(xr[n]);
      inImag[n] <= sampleT'(xi[n]);
      twReal[n] <= sampleT'(wr[n]);
      twImag[n] <= sampleT'(wi[n]);
    end
  endtask

  // called just after a rising edge and returns at the accepting edge
  task automatic startTransform();
    driveData();
    fftStart <= 1'b1;
    @(posedge clk);
    fftStart <= 1'b0;
    acceptEdge = edgeCount;
    checkValue("done width", 0, int'(fftDone));
  endtask

  task automatic finishTransform(input string name);
    int waited;
    waited = 0;
    @(posedge clk);
    while (!fftDone && waited < DoneTimeout) begin
      @(posedge clk);
      waited++;
    end
    if (!fftDone) abortRun($sformatf("timeout waiting for fftDone in %s", name));
    checkValue({name, " latency"}, DoneSeenEdge, edgeCount - acceptEdge);
    checkOutputs(name, 1'b0);
  endtask

  // new input data without a start leaves the result untouched
  task automatic holdCheck();
    fillRandom(1'b0);
    driveData();
    @(posedge clk);
    checkValue("done width", 0, int'(fftDone));
    repeat (2) @(posedge clk);
    checkOutputs("hold", 1'b0);
  endtask

  initial begin
    lfsrState = 32'h8406;
    rst      <= 1'b0;
    fftStart <= 1'b0;
    inReal   <= '0;
    inImag   <= '0;
    twReal   <= '0;
    twImag   <= '0;
    repeat (8) @(posedge clk);
    rst <= 1'b1;
    @(posedge clk);
    checkValue("reset fftDone", 0, int'(fftDone));
    checkOutputs("reset", 1'b1);

    for (int t = 0; t < 20; t++) begin
      fillRandom(1'b0);
      fftModel();
      startTransform();
      finishTransform("random");
      holdCheck();
    end

    // start pulse with other data four cycles in
    fillRandom(1'b0);
    fftModel();
    startTransform();
    repeat (3) @(posedge clk);
    fillRandom(1'b0);
    driveData();
    fftStart <= 1'b1;
    @(posedge clk);
    fftStart <= 1'b0;
    finishTransform("ignored start");

    // next start one cycle after fftDone
    for (int t = 0; t < 4; t++) begin
      fillRandom(1'b0);
      fftModel();
      startTransform();
      finishTransform("back to back");
    end

    for (int t = 0; t < 3; t++) begin
      fillRandom(1'b1);
      fftModel();
      startTransform();
      finishTransform("zero twiddle model");
      checkOutputs("zero twiddle", 1'b1);
    end

    $display("sim passed");
    $finish;
  end

endmodule

// File: sources.f
+incdir+src
src/fftCtrlPkg.sv
src/fftDataPkg.sv
src/twiddleMul.sv
src/butterflyUnit.sv
src/fftController.sv
src/stageRouter.sv
src/fftTop.sv
tb/tbClock.sv
tb/fft_asserts.sv
tb/fftTb.sv

// File: run.sh
#!/bin/sh
# build and run the FFT testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module fftTb -f sources.f -o simFft
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/simFft > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "sim failed" "$LOG"; then
  exit 1
fi
exit 0
